// File: source/mem_chip_pkg.sv
/*
 * Memory chip shared definitions: bus widths, local address map,
 * DMA register offsets and the packed request and response structs
 */
package mem_chip_pkg;

  localparam int unsigned ChipIdWidth    = 8;
  localparam int unsigned AddrWidth      = 48;
  localparam int unsigned LocalAddrWidth = AddrWidth - ChipIdWidth;
  localparam int unsigned DataWidth      = 64;
  localparam int unsigned ByteWidth      = 8;
  localparam int unsigned StrbWidth      = DataWidth / ByteWidth;
  localparam int unsigned SpmWords       = 512;
  localparam int unsigned SpmIdxWidth    = $clog2(SpmWords);
  localparam int unsigned DmaLenWidth    = 10;
  localparam int unsigned DmaOffWidth    = 5;

  //////////////////////////////////////////////////////////////////////
  // Local address map, below the chip ID byte
  //////////////////////////////////////////////////////////////////////

  localparam logic [LocalAddrWidth-1:0] SpmBase  = 40'h00_7000_0000;
  localparam logic [LocalAddrWidth-1:0] SpmBytes = 40'h00_0000_1000;
  localparam logic [LocalAddrWidth-1:0] DmaBase  = 40'h00_0500_0000;
  localparam logic [LocalAddrWidth-1:0] DmaBytes = 40'h00_0000_0020;

  // DMA register byte offsets
  localparam logic [DmaOffWidth-1:0] DmaSrcOff   = 5'h00;
  localparam logic [DmaOffWidth-1:0] DmaDstOff   = 5'h08;
  localparam logic [DmaOffWidth-1:0] DmaLenOff   = 5'h10;
  localparam logic [DmaOffWidth-1:0] DmaStartOff = 5'h18;

  typedef logic [ChipIdWidth-1:0] chip_id_t;
  typedef logic [SpmIdxWidth-1:0] spm_idx_t;

  typedef enum logic [1:0] {
    IdleRegion,
    SpmRegion,
    DmaRegion,
    ErrRegion
  } region_e;

  typedef struct packed {
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
    logic [StrbWidth-1:0] strb;
  } host_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } host_rsp_t;

  // One scratchpad access, word addressed
  typedef struct packed {
    logic                 we;
    spm_idx_t             idx;
    logic [DataWidth-1:0] wdata;
    logic [StrbWidth-1:0] strb;
  } spm_req_t;

  typedef struct packed {
    spm_idx_t               src;
    spm_idx_t               dst;
    logic [DmaLenWidth-1:0] len;
  } dma_cfg_t;

endpackage

// File: source/dma_word_counter.sv
/*
 * Word counter of a DMA copy with a last-word flag
 */
`timescale 1ns/100ps

module dma_word_counter (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 load_i,
  input  logic [mem_chip_pkg::DmaLenWidth-1:0] len_i,
  input  logic                                 step_i,
  output mem_chip_pkg::spm_idx_t                idx_o,
  output logic                                 last_o
);

  // Count is as wide as the length while the index wraps over the array
  logic [mem_chip_pkg::DmaLenWidth-1:0] count_q;
  logic [mem_chip_pkg::DmaLenWidth-1:0] len_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      count_q <= '0;
      len_q   <= '0;
    end else if (load_i) begin
      count_q <= '0;
      len_q   <= len_i;
    end else if (step_i) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign idx_o  = count_q[mem_chip_pkg::SpmIdxWidth-1:0];
  assign last_o = count_q == len_q - 1'b1;

endmodule

// File: source/dma_ctrl_fsm.sv
/*
 * DMA copy control: one scratchpad read followed by one write per
 * word, in ascending order, until the counter flags the last word
 */
`timescale 1ns/100ps

module dma_ctrl_fsm (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  mem_chip_pkg::dma_cfg_t              cfg_i,
  input  logic                               start_i,
  input  logic [mem_chip_pkg::DataWidth-1:0] rdata_i,
  input  mem_chip_pkg::spm_idx_t              idx_i,
  input  logic                               last_i,
  output logic                               spm_valid_o,
  output mem_chip_pkg::spm_req_t              spm_req_o,
  output logic                               load_o,
  output logic                               step_o,
  output logic                               busy_o,
  output logic                               done_o
);

  typedef enum logic [1:0] {
    Idle,
    Read,
    Write
  } state_e;

  state_e state_d;
  state_e state_q;
  logic   go;

  // Zero length starts nothing
  assign go = start_i & (cfg_i.len != '0);

  //////////////////////////////////////////////////////////////////////
  // Next state and scratchpad access
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    spm_valid_o = 1'b0;
    spm_req_o   = '0;
    load_o      = 1'b0;
    step_o      = 1'b0;
    done_o      = 1'b0;
    case (state_q)
      Idle: begin
        if (go) begin
          load_o  = 1'b1;
          state_d = Read;
        end
      end
      Read: begin
        spm_valid_o   = 1'b1;
        spm_req_o.idx = cfg_i.src + idx_i;
        state_d       = Write;
      end
      Write: begin
        spm_valid_o     = 1'b1;
        spm_req_o.we    = 1'b1;
        spm_req_o.idx   = cfg_i.dst + idx_i;
        spm_req_o.wdata = rdata_i;
        spm_req_o.strb  = '1;
        step_o          = 1'b1;
        if (last_i) begin
          done_o  = 1'b1;
          state_d = Idle;
        end else begin
          state_d = Read;
        end
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Busy already in the start cycle so the host loses its grant at once
  assign busy_o = (state_q != Idle) | go;

endmodule

// File: source/dma_regs.sv
/*
 * DMA configuration registers: source, destination and length,
 * registered readback and a one-cycle start pulse
 */
`timescale 1ns/100ps

module dma_regs (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 reg_valid_i,
  input  logic                                 reg_we_i,
  input  logic [mem_chip_pkg::DmaOffWidth-1:0] reg_off_i,
  input  logic [mem_chip_pkg::DataWidth-1:0]   reg_wdata_i,
  output logic [mem_chip_pkg::DataWidth-1:0]   reg_rdata_o,
  output mem_chip_pkg::dma_cfg_t                cfg_o,
  output logic                                 start_o
);

  mem_chip_pkg::dma_cfg_t             cfg_q;
  logic [mem_chip_pkg::DataWidth-1:0] rdata_d;
  logic [mem_chip_pkg::DataWidth-1:0] rdata_q;
  logic                               start_q;
  logic                               wr;

  assign wr = reg_valid_i & reg_we_i;

  // Readback, zero extended; start reads 0
  always_comb begin
    rdata_d = '0;
    case (reg_off_i)
      mem_chip_pkg::DmaSrcOff: rdata_d[mem_chip_pkg::SpmIdxWidth-1:0] = cfg_q.src;
      mem_chip_pkg::DmaDstOff: rdata_d[mem_chip_pkg::SpmIdxWidth-1:0] = cfg_q.dst;
      mem_chip_pkg::DmaLenOff: rdata_d[mem_chip_pkg::DmaLenWidth-1:0] = cfg_q.len;
      default:                 rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      cfg_q   <= '0;
      rdata_q <= '0;
      start_q <= 1'b0;
    end else begin
      start_q <= wr && (reg_off_i == mem_chip_pkg::DmaStartOff);
      if (reg_valid_i) begin
        rdata_q <= rdata_d;
      end
      if (wr) begin
        case (reg_off_i)
          mem_chip_pkg::DmaSrcOff: cfg_q.src <= reg_wdata_i[mem_chip_pkg::SpmIdxWidth-1:0];
          mem_chip_pkg::DmaDstOff: cfg_q.dst <= reg_wdata_i[mem_chip_pkg::SpmIdxWidth-1:0];
          mem_chip_pkg::DmaLenOff: cfg_q.len <= reg_wdata_i[mem_chip_pkg::DmaLenWidth-1:0];
          default:                 cfg_q     <= cfg_q;
        endcase
      end
    end
  end

  assign reg_rdata_o = rdata_q;
  assign cfg_o       = cfg_q;
  assign start_o     = start_q;

endmodule

// File: source/spm_bank.sv
/*
 * Single-port 512x64 scratchpad with byte strobes and a registered
 * read; the DMA port wins over the host port
 */
`timescale 1ns/100ps

module spm_bank (
  input  logic                               clk_i,
  input  logic                               host_valid_i,
  input  mem_chip_pkg::spm_req_t              host_req_i,
  input  logic                               dma_valid_i,
  input  mem_chip_pkg::spm_req_t              dma_req_i,
  output logic [mem_chip_pkg::DataWidth-1:0] rdata_o
);

  logic [mem_chip_pkg::DataWidth-1:0] mem_q [mem_chip_pkg::SpmWords];
  logic                               valid;
  mem_chip_pkg::spm_req_t             req;

  // Port select
  assign valid = dma_valid_i | host_valid_i;
  assign req   = dma_valid_i ? dma_req_i : host_req_i;

  //////////////////////////////////////////////////////////////////////
  // Array write, byte by byte
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (valid && req.we) begin
      for (int unsigned b = 0; b < mem_chip_pkg::StrbWidth; b++) begin
        if (req.strb[b]) begin
          mem_q[req.idx][b*mem_chip_pkg::ByteWidth +: mem_chip_pkg::ByteWidth] <=
            req.wdata[b*mem_chip_pkg::ByteWidth +: mem_chip_pkg::ByteWidth];
        end
      end
    end
  end

  // Read data holds its value across writes
  always_ff @(posedge clk_i) begin
    if (valid && !req.we) begin
      rdata_o <= mem_q[req.idx];
    end
  end

endmodule

// File: source/host_bus_decode.sv
/*
 * Host port: checks the chip ID, decodes the scratchpad and DMA
 * register regions and returns one response per accepted request
 */
`timescale 1ns/100ps

module host_bus_decode (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  mem_chip_pkg::chip_id_t                chip_id_i,
  input  logic                                 req_valid_i,
  input  mem_chip_pkg::host_req_t               req_i,
  input  logic                                 busy_i,
  input  logic [mem_chip_pkg::DataWidth-1:0]   spm_rdata_i,
  input  logic [mem_chip_pkg::DataWidth-1:0]   reg_rdata_i,
  output logic                                 gnt_o,
  output logic                                 spm_valid_o,
  output mem_chip_pkg::spm_req_t                spm_req_o,
  output logic                                 reg_valid_o,
  output logic                                 reg_we_o,
  output logic [mem_chip_pkg::DmaOffWidth-1:0] reg_off_o,
  output logic [mem_chip_pkg::DataWidth-1:0]   reg_wdata_o,
  output logic                                 rsp_valid_o,
  output mem_chip_pkg::host_rsp_t               rsp_o
);

  mem_chip_pkg::chip_id_t                  chip_id_q;
  logic                                    gnt_q;
  logic                                    accept;
  logic                                    id_match;
  logic                                    off_ok;
  logic [mem_chip_pkg::LocalAddrWidth-1:0] local_addr;
  logic [mem_chip_pkg::LocalAddrWidth-1:0] spm_off;
  logic [mem_chip_pkg::LocalAddrWidth-1:0] dma_off;
  mem_chip_pkg::region_e                   region_d;
  mem_chip_pkg::region_e                   region_q;
  logic                                    we_q;

  // Chip ID is sampled for as long as reset is held
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      chip_id_q <= chip_id_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      gnt_q <= 1'b0;
    end else begin
      gnt_q <= 1'b1;
    end
  end

  assign gnt_o  = gnt_q & ~busy_i;
  assign accept = req_valid_i & gnt_o;

  assign local_addr = req_i.addr[mem_chip_pkg::LocalAddrWidth-1:0];
  assign id_match   = req_i.addr[mem_chip_pkg::AddrWidth-1 -: mem_chip_pkg::ChipIdWidth]
                      == chip_id_q;
  // Below a base the difference wraps high and misses the region
  assign spm_off    = local_addr - mem_chip_pkg::SpmBase;
  assign dma_off    = local_addr - mem_chip_pkg::DmaBase;
  assign off_ok     = reg_off_o inside {mem_chip_pkg::DmaSrcOff, mem_chip_pkg::DmaDstOff,
                                        mem_chip_pkg::DmaLenOff, mem_chip_pkg::DmaStartOff};

  always_comb begin
    region_d = mem_chip_pkg::IdleRegion;
    if (accept) begin
      if (!id_match) begin
        region_d = mem_chip_pkg::ErrRegion;
      end else if (spm_off < mem_chip_pkg::SpmBytes) begin
        region_d = mem_chip_pkg::SpmRegion;
      end else if (dma_off < mem_chip_pkg::DmaBytes && off_ok) begin
        region_d = mem_chip_pkg::DmaRegion;
      end else begin
        region_d = mem_chip_pkg::ErrRegion;
      end
    end
  end

  assign spm_valid_o     = region_d == mem_chip_pkg::SpmRegion;
  assign spm_req_o.we    = req_i.we;
  assign spm_req_o.idx   = spm_off[$clog2(mem_chip_pkg::StrbWidth) +: mem_chip_pkg::SpmIdxWidth];
  assign spm_req_o.wdata = req_i.wdata;
  assign spm_req_o.strb  = req_i.strb;

  assign reg_valid_o = region_d == mem_chip_pkg::DmaRegion;
  assign reg_we_o    = req_i.we;
  assign reg_off_o   = dma_off[mem_chip_pkg::DmaOffWidth-1:0];
  assign reg_wdata_o = req_i.wdata;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      region_q <= mem_chip_pkg::IdleRegion;
      we_q     <= 1'b0;
    end else begin
      region_q <= region_d;
      we_q     <= accept & req_i.we;
    end
  end

  // Writes answer with zero data
  assign rsp_valid_o = region_q != mem_chip_pkg::IdleRegion;

  always_comb begin
    rsp_o = '0;
    case (region_q)
      mem_chip_pkg::SpmRegion: rsp_o.rdata = we_q ? '0 : spm_rdata_i;
      mem_chip_pkg::DmaRegion: rsp_o.rdata = we_q ? '0 : reg_rdata_i;
      mem_chip_pkg::ErrRegion: rsp_o.err   = 1'b1;
      default:                 rsp_o       = '0;
    endcase
  end

endmodule

// File: source/mem_chip.sv
/*
 * Memory chip top: host port decode, 512x64 scratchpad and a small
 * DMA engine that copies words inside the scratchpad
 */
`timescale 1ns/100ps

module mem_chip (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  mem_chip_pkg::chip_id_t  chip_id_i,
  input  logic                   req_valid_i,
  input  mem_chip_pkg::host_req_t req_i,
  output logic                   gnt_o,
  output logic                   rsp_valid_o,
  output mem_chip_pkg::host_rsp_t rsp_o,
  output logic                   dma_busy_o,
  output logic                   dma_done_o
);

  logic                                 host_spm_valid;
  mem_chip_pkg::spm_req_t               host_spm_req;
  logic                                 reg_valid;
  logic                                 reg_we;
  logic [mem_chip_pkg::DmaOffWidth-1:0] reg_off;
  logic [mem_chip_pkg::DataWidth-1:0]   reg_wdata;
  logic [mem_chip_pkg::DataWidth-1:0]   reg_rdata;
  logic [mem_chip_pkg::DataWidth-1:0]   spm_rdata;
  mem_chip_pkg::dma_cfg_t               dma_cfg;
  logic                                 start;
  logic                                 dma_spm_valid;
  mem_chip_pkg::spm_req_t               dma_spm_req;
  logic                                 load;
  logic                                 step;
  mem_chip_pkg::spm_idx_t               idx;
  logic                                 last;

  //////////////////////////////////////////////////////////////////////
  // Host side
  //////////////////////////////////////////////////////////////////////

  host_bus_decode i_host_bus_decode (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .chip_id_i  (chip_id_i),
    .req_valid_i(req_valid_i),
    .req_i      (req_i),
    .busy_i     (dma_busy_o),
    .spm_rdata_i(spm_rdata),
    .reg_rdata_i(reg_rdata),
    .gnt_o      (gnt_o),
    .spm_valid_o(host_spm_valid),
    .spm_req_o  (host_spm_req),
    .reg_valid_o(reg_valid),
    .reg_we_o   (reg_we),
    .reg_off_o  (reg_off),
    .reg_wdata_o(reg_wdata),
    .rsp_valid_o(rsp_valid_o),
    .rsp_o      (rsp_o)
  );

  spm_bank i_spm_bank (
    .clk_i       (clk_i),
    .host_valid_i(host_spm_valid),
    .host_req_i  (host_spm_req),
    .dma_valid_i (dma_spm_valid),
    .dma_req_i   (dma_spm_req),
    .rdata_o     (spm_rdata)
  );

  //////////////////////////////////////////////////////////////////////
  // DMA copy engine
  //////////////////////////////////////////////////////////////////////

  dma_regs i_dma_regs (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .reg_valid_i(reg_valid),
    .reg_we_i   (reg_we),
    .reg_off_i  (reg_off),
    .reg_wdata_i(reg_wdata),
    .reg_rdata_o(reg_rdata),
    .cfg_o      (dma_cfg),
    .start_o    (start)
  );

  dma_ctrl_fsm i_dma_ctrl_fsm (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cfg_i      (dma_cfg),
    .start_i    (start),
    .rdata_i    (spm_rdata),
    .idx_i      (idx),
    .last_i     (last),
    .spm_valid_o(dma_spm_valid),
    .spm_req_o  (dma_spm_req),
    .load_o     (load),
    .step_o     (step),
    .busy_o     (dma_busy_o),
    .done_o     (dma_done_o)
  );

  dma_word_counter i_dma_word_counter (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .load_i(load),
    .len_i (dma_cfg.len),
    .step_i(step),
    .idx_o (idx),
    .last_o(last)
  );

endmodule

// File: sim/mem_chip_model.svh
/*
 * Reference model of the memory chip: scratchpad words, DMA fields,
 * sequential ascending copy and the typed compare tasks
 */
`ifndef MEM_CHIP_MODEL_SVH
`define MEM_CHIP_MODEL_SVH

logic [mem_chip_pkg::DataWidth-1:0]   model_mem [mem_chip_pkg::SpmWords];
mem_chip_pkg::spm_idx_t               model_src = '0;
mem_chip_pkg::spm_idx_t               model_dst = '0;
logic [mem_chip_pkg::DmaLenWidth-1:0] model_len = '0;

// Word by word, each read before its write
function automatic void model_copy();
  mem_chip_pkg::spm_idx_t s;
  mem_chip_pkg::spm_idx_t d;
  s = model_src;
  d = model_dst;
  for (int unsigned i = 0; i < 32'(model_len); i++) begin
    model_mem[d] = model_mem[s];
    s = s + 9'd1;
    d = d + 9'd1;
  end
endfunction

// Applies one accepted request and returns the response it must get
function automatic mem_chip_pkg::host_rsp_t model_access(input mem_chip_pkg::host_req_t req);
  mem_chip_pkg::host_rsp_t                 rsp;
  logic [mem_chip_pkg::LocalAddrWidth-1:0] local_a;
  logic [mem_chip_pkg::LocalAddrWidth-1:0] off;
  mem_chip_pkg::spm_idx_t                  idx;
  rsp     = '0;
  local_a = req.addr[39:0];
  off     = '0;
  if (req.addr[47:40] != ChipId) begin
    rsp.err = 1'b1;
  end else if (local_a >= mem_chip_pkg::SpmBase &&
               local_a < mem_chip_pkg::SpmBase + mem_chip_pkg::SpmBytes) begin
    off = local_a - mem_chip_pkg::SpmBase;
    idx = off[11:3];
    if (req.we) begin
      for (int b = 0; b < 8; b++) begin
        if (req.strb[b]) begin
          model_mem[idx][b*8 +: 8] = req.wdata[b*8 +: 8];
        end
      end
    end else begin
      rsp.rdata = model_mem[idx];
    end
  end else if (local_a >= mem_chip_pkg::DmaBase &&
               local_a < mem_chip_pkg::DmaBase + mem_chip_pkg::DmaBytes) begin
    off = local_a - mem_chip_pkg::DmaBase;
    case (off[4:0])
      mem_chip_pkg::DmaSrcOff: begin
        if (req.we) model_src = req.wdata[8:0];
        else rsp.rdata = {55'b0, model_src};
      end
      mem_chip_pkg::DmaDstOff: begin
        if (req.we) model_dst = req.wdata[8:0];
        else rsp.rdata = {55'b0, model_dst};
      end
      mem_chip_pkg::DmaLenOff: begin
        if (req.we) model_len = req.wdata[9:0];
        else rsp.rdata = {54'b0, model_len};
      end
      mem_chip_pkg::DmaStartOff: begin
        if (req.we && model_len != 10'd0) model_copy();
      end
      default: rsp.err = 1'b1;
    endcase
  end else begin
    rsp.err = 1'b1;
  end
  return rsp;
endfunction

//////////////////////////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////////////////////////

task automatic compare_rsp(input string name, input mem_chip_pkg::host_rsp_t exp,
                           input mem_chip_pkg::host_rsp_t act);
  if (act !== exp) begin
    abort_run($sformatf("FAIL at %0d ns: %s expected rdata %h err %b, got rdata %h err %b",
                        $time, name, exp.rdata, exp.err, act.rdata, act.err));
  end
endtask

task automatic compare_word(input string name, input logic [mem_chip_pkg::DataWidth-1:0] exp,
                            input logic [mem_chip_pkg::DataWidth-1:0] act);
  if (act !== exp) begin
    abort_run($sformatf("FAIL at %0d ns: %s expected %h, got %h", $time, name, exp, act));
  end
endtask

task automatic compare_flag(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    abort_run($sformatf("FAIL at %0d ns: %s expected %b, got %b", $time, name, exp, act));
  end
endtask

`endif

// File: sim/mem_chip_tb.sv
/*
 * Memory chip testbench: random host traffic and DMA copies from an
 * LFSR, every response checked against the reference model
 */
`timescale 1ns/100ps

module mem_chip_tb;

  localparam mem_chip_pkg::chip_id_t ChipId = 8'h3C;
  localparam logic [31:0] LfsrTaps     = 32'h8020_0003;
  localparam int          NumFill      = 512;
  localparam int          NumMix       = 64;
  localparam int          NumRegRounds = 4;
  localparam int          NumCopies    = 10;
  localparam int          MaxLen       = 64;
  localparam int ReqCount   = NumFill + 2 * NumMix + 7 * NumRegRounds
                              + NumCopies * (4 + MaxLen) + 32;
  localparam int CycleLimit = 2 * ReqCount + 2 * NumCopies * MaxLen + 200;

  logic                    clk_i;
  logic                    rst_ni;
  mem_chip_pkg::chip_id_t  chip_id_i;
  logic                    req_valid_i;
  mem_chip_pkg::host_req_t req_i;
  logic                    gnt_o;
  logic                    rsp_valid_o;
  mem_chip_pkg::host_rsp_t rsp_o;
  logic                    dma_busy_o;
  logic                    dma_done_o;

  logic [31:0]             lfsr_q      = 32'd94;
  logic                    checks_on   = 1'b0;
  logic                    rsp_due     = 1'b0;
  logic                    word_check  = 1'b0;
  logic                    busy_exp    = 1'b0;
  int                      cycle_count = 0;
  mem_chip_pkg::host_rsp_t exp_q [$];
  logic                    word_q [$];
  mem_chip_pkg::host_rsp_t exp_rsp;
  logic                    exp_by_word;
  mem_chip_pkg::spm_idx_t  idx_list [NumMix];

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped");
  endtask

  `include "mem_chip_model.svh"

  mem_chip i_dut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .chip_id_i  (chip_id_i),
    .req_valid_i(req_valid_i),
    .req_i      (req_i),
    .gnt_o      (gnt_o),
    .rsp_valid_o(rsp_valid_o),
    .rsp_o      (rsp_o),
    .dma_busy_o (dma_busy_o),
    .dma_done_o (dma_done_o)
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CycleLimit) begin
      abort_run($sformatf("Timeout after %0d cycles, the test sequence did not finish",
                          cycle_count));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Response monitor, sampled at the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (checks_on) begin
      compare_flag("dma_busy_o", busy_exp, dma_busy_o);
      compare_flag("gnt_o", ~busy_exp, gnt_o);
      if (!busy_exp) begin
        compare_flag("dma_done_o", 1'b0, dma_done_o);
      end
      if (rsp_valid_o !== rsp_due) begin
        if (rsp_due) abort_run("No response arrived one cycle after an accepted request");
        else abort_run("A response arrived without an accepted request");
      end
      if (rsp_due) begin
        exp_rsp     = exp_q.pop_front();
        exp_by_word = word_q.pop_front();
        if (exp_by_word) begin
          compare_word("rsp_o.rdata", exp_rsp.rdata, rsp_o.rdata);
          compare_flag("rsp_o.err", exp_rsp.err, rsp_o.err);
        end else begin
          compare_rsp("rsp_o", exp_rsp, rsp_o);
        end
      end
      // Accepted at the next rising edge
      rsp_due = req_valid_i & gnt_o;
      if (rsp_due) begin
        exp_q.push_back(model_access(req_i));
        word_q.push_back(word_check);
      end
    end
  end

  // Galois LFSR, one step per bit
  function automatic logic next_bit();
    if (lfsr_q[0]) lfsr_q = (lfsr_q >> 1) ^ LfsrTaps;
    else lfsr_q = lfsr_q >> 1;
    return lfsr_q[0];
  endfunction

  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) v = {v[62:0], next_bit()};
    return v;
  endfunction

  function automatic logic [47:0] spm_addr(input mem_chip_pkg::spm_idx_t idx);
    return {ChipId, mem_chip_pkg::SpmBase + {28'b0, idx, 3'b000}};
  endfunction

  function automatic logic [47:0] reg_addr(input logic [4:0] off);
    return {ChipId, mem_chip_pkg::DmaBase + {35'b0, off}};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Bus driver
  //////////////////////////////////////////////////////////////////////

  task automatic send(input logic we, input logic [47:0] addr, input logic [63:0] wdata,
                      input logic [7:0] strb);
    mem_chip_pkg::host_req_t req;
    req.we    = we;
    req.addr  = addr;
    req.wdata = wdata;
    req.strb  = strb;
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_i       <= req;
    @(negedge clk_i);
    while (gnt_o !== 1'b1) @(negedge clk_i);
  endtask

  task automatic release_bus();
    @(posedge clk_i);
    req_valid_i <= 1'b0;
  endtask

  task automatic spm_write(input mem_chip_pkg::spm_idx_t idx, input logic [63:0] data,
                           input logic [7:0] strb);
    send(1'b1, spm_addr(idx), data, strb);
  endtask

  task automatic spm_read(input mem_chip_pkg::spm_idx_t idx);
    send(1'b0, spm_addr(idx), rand_bits(64), 8'h00);
  endtask

  task automatic reg_write(input logic [4:0] off, input logic [63:0] data);
    send(1'b1, reg_addr(off), data, 8'hFF);
  endtask

  task automatic reg_read(input logic [4:0] off);
    send(1'b0, reg_addr(off), 64'h0, 8'h00);
  endtask

  // Follows busy and done after the start write was accepted
  task automatic watch_dma(input logic [9:0] len);
    int unsigned waited;
    int unsigned limit;
    waited = 0;
    limit  = 2 * 32'(len) + 4;
    if (len == 10'd0) begin
      repeat (8) begin
        @(negedge clk_i);
        compare_flag("dma_busy_o", 1'b0, dma_busy_o);
        compare_flag("dma_done_o", 1'b0, dma_done_o);
        compare_flag("gnt_o", 1'b1, gnt_o);
      end
    end else begin
      busy_exp = 1'b1;
      do begin
        @(negedge clk_i);
        waited++;
        if (waited > limit) abort_run("dma_done_o never pulsed during the copy");
      end while (dma_done_o !== 1'b1);
      // Busy drops in the cycle after the last write
      @(posedge clk_i);
      busy_exp = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test phases
  //////////////////////////////////////////////////////////////////////

  task automatic fill_and_mix();
    logic [63:0] rnd;
    for (int i = 0; i < NumFill; i++) spm_write(9'(i), rand_bits(64), 8'hFF);
    for (int k = 0; k < NumMix; k++) begin
      rnd         = rand_bits(9);
      idx_list[k] = rnd[8:0];
      rnd         = rand_bits(8);
      spm_write(idx_list[k], rand_bits(64), rnd[7:0]);
    end
    for (int k = 0; k < NumMix; k++) spm_read(idx_list[k]);
    release_bus();
  endtask

  task automatic bad_requests();
    logic [63:0] rnd;
    logic [47:0] addr;
    rnd  = rand_bits(9);
    addr = spm_addr(rnd[8:0]);
    addr[47:40] = ~ChipId;
    send(1'b1, addr, rand_bits(64), 8'hFF);
    // The ID now on the pins is not the one captured in reset
    addr[47:40] = chip_id_i;
    send(1'b1, addr, rand_bits(64), 8'hFF);
    send(1'b0, addr, 64'h0, 8'h00);
    send(1'b1, {ChipId, 40'h00_1234_5678}, rand_bits(64), 8'hFF);
    send(1'b1, {ChipId, mem_chip_pkg::SpmBase + mem_chip_pkg::SpmBytes}, rand_bits(64), 8'hFF);
    send(1'b1, {ChipId, mem_chip_pkg::DmaBase + mem_chip_pkg::DmaBytes}, rand_bits(64), 8'hFF);
    reg_write(5'h04, rand_bits(64));
    reg_write(5'h1C, rand_bits(64));
    reg_read(5'h0C);
    spm_read(rnd[8:0]);
    reg_read(mem_chip_pkg::DmaSrcOff);
    reg_read(mem_chip_pkg::DmaDstOff);
    reg_read(mem_chip_pkg::DmaLenOff);
    release_bus();
  endtask

  task automatic reg_readback();
    repeat (NumRegRounds) begin
      reg_write(mem_chip_pkg::DmaSrcOff, rand_bits(64));
      reg_write(mem_chip_pkg::DmaDstOff, rand_bits(64));
      reg_write(mem_chip_pkg::DmaLenOff, rand_bits(64));
      reg_read(mem_chip_pkg::DmaSrcOff);
      reg_read(mem_chip_pkg::DmaDstOff);
      reg_read(mem_chip_pkg::DmaLenOff);
      reg_read(mem_chip_pkg::DmaStartOff);
    end
    release_bus();
  endtask

  task automatic run_copy(input mem_chip_pkg::spm_idx_t src, input mem_chip_pkg::spm_idx_t dst,
                          input logic [9:0] len);
    reg_write(mem_chip_pkg::DmaSrcOff, {55'b0, src});
    reg_write(mem_chip_pkg::DmaDstOff, {55'b0, dst});
    reg_write(mem_chip_pkg::DmaLenOff, {54'b0, len});
    reg_write(mem_chip_pkg::DmaStartOff, rand_bits(64));
    release_bus();
    watch_dma(len);
    word_check = 1'b1;
    for (int unsigned i = 0; i < 32'(len); i++) spm_read(dst + 9'(i));
    release_bus();
    word_check = 1'b0;
  endtask

  task automatic copies();
    logic [63:0] rnd;
    logic [63:0] rnd2;
    logic [63:0] rlen;
    rnd = rand_bits(9);
    run_copy(9'd500, rnd[8:0], 10'd30);
    rnd = rand_bits(9);
    run_copy(rnd[8:0], 9'd505, 10'd20);
    // Overlapping ranges in both directions
    rnd = rand_bits(9);
    run_copy(rnd[8:0], rnd[8:0] + 9'd3, 10'd40);
    rnd = rand_bits(9);
    run_copy(rnd[8:0], rnd[8:0] - 9'd3, 10'd40);
    for (int k = 0; k < NumCopies - 4; k++) begin
      rnd  = rand_bits(9);
      rnd2 = rand_bits(9);
      rlen = rand_bits(6);
      run_copy(rnd[8:0], rnd2[8:0], {4'b0, rlen[5:0]} + 10'd1);
    end
  endtask

  task automatic zero_length();
    logic [63:0] rnd;
    rnd = rand_bits(54);
    reg_write(mem_chip_pkg::DmaLenOff, {rnd[53:0], 10'b0});
    reg_write(mem_chip_pkg::DmaStartOff, rand_bits(64));
    release_bus();
    watch_dma(10'd0);
    reg_read(mem_chip_pkg::DmaLenOff);
    release_bus();
  endtask

  initial begin
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    chip_id_i   = ChipId;
    req_valid_i = 1'b0;
    req_i       = '0;
    repeat (15) @(posedge clk_i);
    // Outputs held low in reset
    @(negedge clk_i);
    compare_flag("gnt_o", 1'b0, gnt_o);
    compare_flag("rsp_valid_o", 1'b0, rsp_valid_o);
    compare_flag("dma_busy_o", 1'b0, dma_busy_o);
    compare_flag("dma_done_o", 1'b0, dma_done_o);
    @(posedge clk_i);
    rst_ni    <= 1'b1;
    chip_id_i <= 8'hA5;
    @(posedge clk_i);
    checks_on = 1'b1;
    fill_and_mix();
    bad_requests();
    reg_readback();
    copies();
    zero_length();
    repeat (2) @(negedge clk_i);
    if (exp_q.size() != 0) begin
      abort_run("Responses still outstanding at the end of the run");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

// File: all.f
+incdir+sim
source/mem_chip_pkg.sv
source/dma_word_counter.sv
source/dma_ctrl_fsm.sv
source/dma_regs.sv
source/spm_bank.sv
source/host_bus_decode.sv
source/mem_chip.sv
sim/mem_chip_tb.sv

// File: Makefile
TOP = mem_chip_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

obj_dir/V$(TOP): all.f $(wildcard source/*.sv sim/*.sv sim/*.svh)
	verilator --binary --timing -f all.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q '^TEST PASS$$'

clean:
	rm -rf obj_dir
